//--- common/rtos_cmd_if.sv
`timescale 1ns/1ps

interface rtos_cmd_if import rtos_pkg::*; ();

    // one-cycle strobes, all from acknowledged transfers
    logic        wup;
    logic        slp;
    logic        sig;
    logic        pol;
    logic        set_flg;
    logic        clr_flg;
    logic        ena_ext;
    logic        run_wr;
    logic        copy;
    logic        cpu_wr;
    logic        soft_reset;

    // operands, follow the address and data lines
    cpu_ctl_id_e cpu_id;
    tskid_t      tskid;
    semid_t      semid;
    wb_data_t    wdata;

    modport ctl (
        output wup, slp, sig, pol, set_flg, clr_flg, ena_ext,
        output run_wr, copy, cpu_wr, soft_reset,
        output cpu_id, tskid, semid, wdata
    );

    modport rdq (input wup, slp, tskid, soft_reset);
    modport sem (input sig, pol, semid, soft_reset);
    modport flg (input set_flg, clr_flg, ena_ext, wdata, soft_reset);
    modport cpu (input run_wr, copy, cpu_wr, cpu_id, wdata, soft_reset);

endinterface

//--- common/rtos_consts.svh
`ifndef RTOS_CONSTS_SVH
`define RTOS_CONSTS_SVH

// object counts
`define RTOS_TASKS          15
`define RTOS_SEMAPHORES     8

// kernel widths, task id wide enough for the idle id too
`define RTOS_TSKID_WIDTH    4
`define RTOS_SEMID_WIDTH    3
`define RTOS_SEMCNT_WIDTH   4
`define RTOS_FLGPTN_WIDTH   32

// wishbone
`define RTOS_WB_ADR_WIDTH   16
`define RTOS_WB_DAT_WIDTH   32
`define RTOS_WB_SEL_WIDTH   4

// address split, opcode above id
`define RTOS_ID_WIDTH       8
`define RTOS_OPCODE_WIDTH   8

// opcode values
`define RTOS_OP_SYS_CFG     8'h00
`define RTOS_OP_CPU_CTL     8'h01
`define RTOS_OP_WUP_TSK     8'h10
`define RTOS_OP_SLP_TSK     8'h11
`define RTOS_OP_SIG_SEM     8'h21
`define RTOS_OP_POL_SEM     8'h23
`define RTOS_OP_REF_SEMCNT  8'h28
`define RTOS_OP_SET_FLG     8'h31
`define RTOS_OP_CLR_FLG     8'h32
`define RTOS_OP_ENA_FLG_EXT 8'h3a

`define RTOS_CORE_ID        32'h834f5452

`endif

//--- common/rtos_pkg.sv
`include "rtos_consts.svh"

package rtos_pkg;

    typedef enum logic [`RTOS_OPCODE_WIDTH-1:0] {
        SYS_CFG     = `RTOS_OP_SYS_CFG,
        CPU_CTL     = `RTOS_OP_CPU_CTL,
        WUP_TSK     = `RTOS_OP_WUP_TSK,
        SLP_TSK     = `RTOS_OP_SLP_TSK,
        SIG_SEM     = `RTOS_OP_SIG_SEM,
        POL_SEM     = `RTOS_OP_POL_SEM,
        REF_SEMCNT  = `RTOS_OP_REF_SEMCNT,
        SET_FLG     = `RTOS_OP_SET_FLG,
        CLR_FLG     = `RTOS_OP_CLR_FLG,
        ENA_FLG_EXT = `RTOS_OP_ENA_FLG_EXT
    } opcode_e;

    // ids under SYS_CFG
    typedef enum logic [`RTOS_ID_WIDTH-1:0] {
        CORE_ID      = 8'h00,
        TASKS        = 8'h20,
        SEMAPHORES   = 8'h21,
        SEMCNT_WIDTH = 8'h31,
        FLGPTN_WIDTH = 8'h32,
        SOFT_RESET   = 8'hff
    } sys_cfg_id_e;

    // ids under CPU_CTL
    typedef enum logic [`RTOS_ID_WIDTH-1:0] {
        TOP_TSKID  = 8'h00,
        TOP_VALID  = 8'h01,
        RUN_TSKID  = 8'h04,
        RUN_VALID  = 8'h05,
        IDLE_TSKID = 8'h07,
        COPY_TSKID = 8'h08,
        IRQ_EN     = 8'h10,
        IRQ_STS    = 8'h11,
        IRQ_FORCE  = 8'h1f,
        SCRATCH0   = 8'he0,
        SCRATCH1   = 8'he1,
        SCRATCH2   = 8'he2,
        SCRATCH3   = 8'he3
    } cpu_ctl_id_e;

    typedef logic [`RTOS_TSKID_WIDTH-1:0]  tskid_t;
    typedef logic [`RTOS_SEMID_WIDTH-1:0]  semid_t;
    typedef logic [`RTOS_SEMCNT_WIDTH-1:0] semcnt_t;
    typedef logic [`RTOS_FLGPTN_WIDTH-1:0] flgptn_t;
    typedef logic [`RTOS_WB_DAT_WIDTH-1:0] wb_data_t;

endpackage

//--- core/rtos_eventflag.sv
`timescale 1ns/1ps

module rtos_eventflag import rtos_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    rtos_cmd_if.flg cmd,
    input  flgptn_t ext_flg_i,
    output flgptn_t flgptn_o
);

    flgptn_t ext_en_q;
    flgptn_t set_d;
    flgptn_t clr_d;

    // clear keeps the bits written as ones
    assign set_d = cmd.set_flg ? flgptn_t'(cmd.wdata) : '0;
    assign clr_d = cmd.clr_flg ? flgptn_t'(cmd.wdata) : '1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flgptn_o <= '0;
            ext_en_q <= '0;
        end else if (cmd.soft_reset) begin
            flgptn_o <= '0;
            ext_en_q <= '0;
        end else begin
            // enabled external flags merge in every cycle
            flgptn_o <= ((flgptn_o | set_d) & clr_d) | (ext_flg_i & ext_en_q);
            if (cmd.ena_ext) begin
                ext_en_q <= flgptn_t'(cmd.wdata);
            end
        end
    end

endmodule

//--- core/rtos_ready_queue.sv
`timescale 1ns/1ps
`include "rtos_consts.svh"

module rtos_ready_queue import rtos_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    rtos_cmd_if.rdq cmd,
    output tskid_t  top_tskid_o,
    output logic    top_valid_o,
    output logic    busy_o
);

    logic [`RTOS_TASKS-1:0] ready_q;
    tskid_t                 next_tskid;
    logic                   next_valid;
    logic                   id_ok;

    // id 15 is the idle task and never queued
    assign id_ok = (cmd.tskid < `RTOS_TASKS);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= '0;
            busy_o  <= 1'b0;
        end else begin
            busy_o <= cmd.wup || cmd.slp || cmd.soft_reset;
            if (cmd.soft_reset) begin
                ready_q <= '0;
            end else if (cmd.wup && id_ok) begin
                ready_q[cmd.tskid] <= 1'b1;
            end else if (cmd.slp && id_ok) begin
                ready_q[cmd.tskid] <= 1'b0;
            end
        end
    end

    // lowest ready id wins
    always_comb begin
        next_tskid = '0;
        next_valid = 1'b0;
        for (int i = `RTOS_TASKS - 1; i >= 0; i--) begin
            if (ready_q[i]) begin
                next_tskid = tskid_t'(i);
                next_valid = 1'b1;
            end
        end
    end

    // top refreshed during the busy cycle only
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            top_tskid_o <= '0;
            top_valid_o <= 1'b0;
        end else if (busy_o) begin
            top_tskid_o <= next_tskid;
            top_valid_o <= next_valid;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (top_valid_o && !busy_o) |-> ready_q[top_tskid_o]);

endmodule

//--- core/rtos_semaphore.sv
`timescale 1ns/1ps
`include "rtos_consts.svh"

module rtos_semaphore import rtos_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n_i,
    rtos_cmd_if.sem                        cmd,
    output logic                           pol_ack_o,
    output semcnt_t                        semcnt_o,
    output semcnt_t [`RTOS_SEMAPHORES-1:0] semcnt_all_o
);

    semcnt_t [`RTOS_SEMAPHORES-1:0] semcnt_q;

    assign semcnt_o     = semcnt_q[cmd.semid];
    assign semcnt_all_o = semcnt_q;

    // poll result from the count before the decrement
    assign pol_ack_o = (semcnt_o != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            semcnt_q <= '0;
        end else if (cmd.soft_reset) begin
            semcnt_q <= '0;
        end else if (cmd.sig && semcnt_o != '1) begin
            // saturates at the top of the counter
            semcnt_q[cmd.semid] <= semcnt_o + 1'b1;
        end else if (cmd.pol && pol_ack_o) begin
            semcnt_q[cmd.semid] <= semcnt_o - 1'b1;
        end
    end

    for (genvar i = 0; i < `RTOS_SEMAPHORES; i++) begin : g_sat_chk
        assert property (@(posedge clk) disable iff (!rst_n_i)
            (semcnt_q[i] == '1 && !cmd.soft_reset) |=> semcnt_q[i] != '0);
    end

endmodule

//--- hdl/rtos_cpu_ctl.sv
`timescale 1ns/1ps
`include "rtos_consts.svh"

module rtos_cpu_ctl import rtos_pkg::*; (
    input  logic           clk,
    input  logic           rst_n_i,
    rtos_cmd_if.cpu        cmd,
    input  logic           busy_i,
    input  tskid_t         top_tskid_i,
    input  logic           top_valid_i,
    output tskid_t         run_tskid_o,
    output logic           run_valid_o,
    output tskid_t         idle_tskid_o,
    output logic           irq_en_o,
    output wb_data_t [3:0] scratch_o,
    output logic           irq_o
);

    logic irq_force_q;
    logic switch_q;
    logic irq_q;
    logic differ;

    // invalid top or run compare as the idle task
    assign differ = (top_valid_i ? top_tskid_i : idle_tskid_o)
                 != (run_valid_o ? run_tskid_o : idle_tskid_o);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_tskid_o  <= '0;
            run_valid_o  <= 1'b0;
            idle_tskid_o <= tskid_t'(`RTOS_TASKS);
            irq_en_o     <= 1'b0;
            irq_force_q  <= 1'b0;
            scratch_o    <= '0;
            switch_q     <= 1'b0;
            irq_q        <= 1'b0;
        end else if (cmd.soft_reset) begin
            run_tskid_o  <= '0;
            run_valid_o  <= 1'b0;
            idle_tskid_o <= tskid_t'(`RTOS_TASKS);
            irq_en_o     <= 1'b0;
            irq_force_q  <= 1'b0;
            scratch_o    <= '0;
            switch_q     <= 1'b0;
            irq_q        <= 1'b0;
        end else begin
            if (cmd.run_wr) begin
                run_tskid_o <= tskid_t'(cmd.wdata);
                run_valid_o <= (cmd.wdata < `RTOS_TASKS);
            end

            // COPY_TSKID read, the processor takes the top task
            if (cmd.copy) begin
                run_tskid_o <= top_tskid_i;
                run_valid_o <= top_valid_i;
            end

            if (cmd.cpu_wr) begin
                case (cmd.cpu_id)
                    RUN_VALID:  run_valid_o  <= cmd.wdata[0];
                    IDLE_TSKID: idle_tskid_o <= tskid_t'(cmd.wdata);
                    IRQ_EN:     irq_en_o     <= cmd.wdata[0];
                    IRQ_FORCE:  irq_force_q  <= cmd.wdata[0];
                    SCRATCH0, SCRATCH1, SCRATCH2, SCRATCH3:
                        scratch_o[cmd.cpu_id[1:0]] <= cmd.wdata;
                    default: ;
                endcase
            end

            // two non-busy cycles of mismatch in a row raise the irq
            if (!busy_i) begin
                switch_q <= differ;
                irq_q    <= differ && switch_q;
            end
        end
    end

    assign irq_o = (irq_q && irq_en_o) || irq_force_q;

endmodule

//--- hdl/rtos_top.sv
`timescale 1ns/1ps
`include "rtos_consts.svh"

module rtos_top import rtos_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [`RTOS_WB_ADR_WIDTH-1:0]  wb_adr_i,
    input  wb_data_t                       wb_dat_i,
    output wb_data_t                       wb_dat_o,
    input  logic                           wb_we_i,
    input  logic [`RTOS_WB_SEL_WIDTH-1:0]  wb_sel_i,
    input  logic                           wb_stb_i,
    output logic                           wb_ack_o,
    output logic                           irq_o,
    input  flgptn_t                        ext_flg_i,
    output tskid_t                         monitor_top_tskid_o,
    output tskid_t                         monitor_run_tskid_o,
    output flgptn_t                        monitor_flg_o,
    output semcnt_t [`RTOS_SEMAPHORES-1:0] monitor_semcnt_o
);

    logic           busy;
    tskid_t         top_tskid;
    logic           top_valid;
    tskid_t         run_tskid;
    logic           run_valid;
    tskid_t         idle_tskid;
    logic           irq_en;
    wb_data_t [3:0] scratch;
    logic           pol_ack;
    semcnt_t        semcnt;

    rtos_cmd_if cmd_if ();

    // ----------------------------------------------------------------------
    // bus side
    // ----------------------------------------------------------------------

    rtos_wb_ctl u_wb_ctl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_we_i      (wb_we_i),
        .wb_sel_i     (wb_sel_i),
        .wb_stb_i     (wb_stb_i),
        .wb_ack_o     (wb_ack_o),
        .busy_i       (busy),
        .top_tskid_i  (top_tskid),
        .top_valid_i  (top_valid),
        .run_tskid_i  (run_tskid),
        .run_valid_i  (run_valid),
        .idle_tskid_i (idle_tskid),
        .irq_en_i     (irq_en),
        .irq_sts_i    (irq_o),
        .scratch_i    (scratch),
        .pol_ack_i    (pol_ack),
        .semcnt_i     (semcnt),
        .cmd          (cmd_if.ctl)
    );

    rtos_cpu_ctl u_cpu_ctl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cmd          (cmd_if.cpu),
        .busy_i       (busy),
        .top_tskid_i  (top_tskid),
        .top_valid_i  (top_valid),
        .run_tskid_o  (run_tskid),
        .run_valid_o  (run_valid),
        .idle_tskid_o (idle_tskid),
        .irq_en_o     (irq_en),
        .scratch_o    (scratch),
        .irq_o        (irq_o)
    );

    // ----------------------------------------------------------------------
    // kernel objects
    // ----------------------------------------------------------------------

    rtos_ready_queue u_ready_queue (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd         (cmd_if.rdq),
        .top_tskid_o (top_tskid),
        .top_valid_o (top_valid),
        .busy_o      (busy)
    );

    rtos_semaphore u_semaphore (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cmd          (cmd_if.sem),
        .pol_ack_o    (pol_ack),
        .semcnt_o     (semcnt),
        .semcnt_all_o (monitor_semcnt_o)
    );

    rtos_eventflag u_eventflag (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .cmd       (cmd_if.flg),
        .ext_flg_i (ext_flg_i),
        .flgptn_o  (monitor_flg_o)
    );

    assign monitor_top_tskid_o = top_tskid;
    assign monitor_run_tskid_o = run_tskid;

endmodule

//--- hdl/rtos_wb_ctl.sv
`timescale 1ns/1ps
`include "rtos_consts.svh"

module rtos_wb_ctl import rtos_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [`RTOS_WB_ADR_WIDTH-1:0] wb_adr_i,
    input  wb_data_t                      wb_dat_i,
    output wb_data_t                      wb_dat_o,
    input  logic                          wb_we_i,
    input  logic [`RTOS_WB_SEL_WIDTH-1:0] wb_sel_i,
    input  logic                          wb_stb_i,
    output logic                          wb_ack_o,
    input  logic                          busy_i,
    input  tskid_t                        top_tskid_i,
    input  logic                          top_valid_i,
    input  tskid_t                        run_tskid_i,
    input  logic                          run_valid_i,
    input  tskid_t                        idle_tskid_i,
    input  logic                          irq_en_i,
    input  logic                          irq_sts_i,
    input  wb_data_t [3:0]                scratch_i,
    input  logic                          pol_ack_i,
    input  semcnt_t                       semcnt_i,
    rtos_cmd_if.ctl                       cmd
);

    opcode_e                   opcode;
    cpu_ctl_id_e               cpu_id;
    logic [`RTOS_ID_WIDTH-1:0] id;
    logic                      wr;
    logic                      rd;
    logic                      tsk_ok;
    logic                      sem_ok;
    logic                      soft_reset_q;
    tskid_t                    cur_top;
    tskid_t                    cur_run;

    assign opcode = opcode_e'(wb_adr_i[`RTOS_ID_WIDTH +: `RTOS_OPCODE_WIDTH]);
    assign id     = wb_adr_i[`RTOS_ID_WIDTH-1:0];
    assign cpu_id = cpu_ctl_id_e'(id);

    // held off only while the top task is recomputed
    assign wb_ack_o = wb_stb_i && !busy_i;

    // partial byte lanes are acked but do nothing
    assign wr = wb_ack_o && (&wb_sel_i) && wb_we_i;
    assign rd = wb_ack_o && (&wb_sel_i) && !wb_we_i;

    // keep ids that would alias after truncation away from the blocks
    assign tsk_ok = (id >> `RTOS_TSKID_WIDTH) == '0;
    assign sem_ok = (id < `RTOS_SEMAPHORES);

    // ----------------------------------------------------------------------
    // command strobes
    // ----------------------------------------------------------------------

    assign cmd.tskid      = tskid_t'(id);
    assign cmd.semid      = semid_t'(id);
    assign cmd.cpu_id     = cpu_id;
    assign cmd.wdata      = wb_dat_i;
    assign cmd.wup        = wr && opcode == WUP_TSK && tsk_ok;
    assign cmd.slp        = wr && opcode == SLP_TSK && tsk_ok;
    assign cmd.sig        = wr && opcode == SIG_SEM && sem_ok;
    assign cmd.pol        = rd && opcode == POL_SEM && sem_ok;
    assign cmd.set_flg    = wr && opcode == SET_FLG;
    assign cmd.clr_flg    = wr && opcode == CLR_FLG;
    assign cmd.ena_ext    = wr && opcode == ENA_FLG_EXT;
    assign cmd.run_wr     = wr && opcode == CPU_CTL && cpu_id == RUN_TSKID;
    assign cmd.cpu_wr     = wr && opcode == CPU_CTL && cpu_id != RUN_TSKID;
    assign cmd.copy       = rd && opcode == CPU_CTL && cpu_id == COPY_TSKID;
    assign cmd.soft_reset = soft_reset_q;

    // soft reset lands on the blocks one edge after the write
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            soft_reset_q <= 1'b0;
        end else begin
            soft_reset_q <= wr && opcode == SYS_CFG && sys_cfg_id_e'(id) == SOFT_RESET;
        end
    end

    // ----------------------------------------------------------------------
    // read data
    // ----------------------------------------------------------------------

    // invalid entries read back as the idle task
    assign cur_top = top_valid_i ? top_tskid_i : idle_tskid_i;
    assign cur_run = run_valid_i ? run_tskid_i : idle_tskid_i;

    always_comb begin
        wb_dat_o = '0;
        case (opcode)
            SYS_CFG: begin
                case (sys_cfg_id_e'(id))
                    CORE_ID:      wb_dat_o = `RTOS_CORE_ID;
                    TASKS:        wb_dat_o = wb_data_t'(`RTOS_TASKS);
                    SEMAPHORES:   wb_dat_o = wb_data_t'(`RTOS_SEMAPHORES);
                    SEMCNT_WIDTH: wb_dat_o = wb_data_t'(`RTOS_SEMCNT_WIDTH);
                    FLGPTN_WIDTH: wb_dat_o = wb_data_t'(`RTOS_FLGPTN_WIDTH);
                    default:      wb_dat_o = '0;
                endcase
            end
            CPU_CTL: begin
                case (cpu_id)
                    TOP_TSKID:  wb_dat_o = wb_data_t'(cur_top);
                    TOP_VALID:  wb_dat_o = wb_data_t'(top_valid_i);
                    RUN_TSKID:  wb_dat_o = wb_data_t'(cur_run);
                    RUN_VALID:  wb_dat_o = wb_data_t'(run_valid_i);
                    IDLE_TSKID: wb_dat_o = wb_data_t'(idle_tskid_i);
                    // returns the id being copied into run
                    COPY_TSKID: wb_dat_o = wb_data_t'(cur_top);
                    IRQ_EN:     wb_dat_o = wb_data_t'(irq_en_i);
                    IRQ_STS:    wb_dat_o = wb_data_t'(irq_sts_i);
                    SCRATCH0:   wb_dat_o = scratch_i[0];
                    SCRATCH1:   wb_dat_o = scratch_i[1];
                    SCRATCH2:   wb_dat_o = scratch_i[2];
                    SCRATCH3:   wb_dat_o = scratch_i[3];
                    default:    wb_dat_o = '0;
                endcase
            end
            POL_SEM:    wb_dat_o = wb_data_t'(pol_ack_i && sem_ok);
            REF_SEMCNT: wb_dat_o = sem_ok ? wb_data_t'(semcnt_i) : '0;
            default:    wb_dat_o = '0;
        endcase
    end

    // a ready set update or soft reset always stalls the following transfer
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (cmd.wup || cmd.slp || cmd.soft_reset) |=> !wb_ack_o);

endmodule

//--- project.f
+incdir+common
common/rtos_pkg.sv
common/rtos_cmd_if.sv
core/rtos_ready_queue.sv
core/rtos_semaphore.sv
core/rtos_eventflag.sv
hdl/rtos_cpu_ctl.sv
hdl/rtos_wb_ctl.sv
hdl/rtos_top.sv
testbench/tb_clkgen.sv
testbench/tb_rtos.sv

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_o = 1'b1;
    end

endmodule

//--- testbench/tb_rtos.sv
`timescale 1ns/1ps
`include "rtos_consts.svh"

module tb_rtos import rtos_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int ACK_WAIT_LIMIT = 8;
    localparam int IRQ_WAIT_LIMIT = 4;

    logic                           clk;
    logic                           rst_n;
    logic [`RTOS_WB_ADR_WIDTH-1:0]  wb_adr;
    wb_data_t                       wb_wdata;
    wb_data_t                       wb_rdata;
    logic                           wb_we;
    logic [`RTOS_WB_SEL_WIDTH-1:0]  wb_sel;
    logic                           wb_stb;
    logic                           wb_ack;
    logic                           irq;
    flgptn_t                        ext_flg;
    tskid_t                         mon_top;
    tskid_t                         mon_run;
    flgptn_t                        mon_flg;
    semcnt_t [`RTOS_SEMAPHORES-1:0] mon_semcnt;

    // reference model of the kernel state
    logic [14:0] ready_model;
    semcnt_t     cnt_model [8];
    flgptn_t     flg_model;
    wb_data_t    scratch_model [4];
    int          cycle_cnt = 0;
    int          last_stalls;

    tb_clkgen u_clkgen (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    rtos_top dut0 (
        .clk                 (clk),
        .rst_n_i             (rst_n),
        .wb_adr_i            (wb_adr),
        .wb_dat_i            (wb_wdata),
        .wb_dat_o            (wb_rdata),
        .wb_we_i             (wb_we),
        .wb_sel_i            (wb_sel),
        .wb_stb_i            (wb_stb),
        .wb_ack_o            (wb_ack),
        .irq_o               (irq),
        .ext_flg_i           (ext_flg),
        .monitor_top_tskid_o (mon_top),
        .monitor_run_tskid_o (mon_run),
        .monitor_flg_o       (mon_flg),
        .monitor_semcnt_o    (mon_semcnt)
    );

    // --------------------------------------------------------------------
    // verdict and compare helpers
    // --------------------------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, no verdict after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error @%0t: %s = 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_tskid(input string name, input tskid_t got, input tskid_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error @%0t: %s = %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_semcnt(input string name, input semcnt_t got, input semcnt_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error @%0t: %s = %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flgptn(input string name, input flgptn_t got, input flgptn_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error @%0t: %s = 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error @%0t: %s = %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // --------------------------------------------------------------------
    // bus access, entered and left on a falling edge
    // --------------------------------------------------------------------

    task automatic bus_cycle(input opcode_e op, input logic [7:0] id, input logic we,
                             input logic [3:0] sel, input wb_data_t wdata,
                             output wb_data_t rdata);
        wb_adr      = {op, id};
        wb_wdata    = wdata;
        wb_we       = we;
        wb_sel      = sel;
        wb_stb      = 1'b1;
        last_stalls = 0;
        #1;
        while (!wb_ack) begin
            last_stalls++;
            if (last_stalls > ACK_WAIT_LIMIT) begin
                abort_run($sformatf("no ack for the transfer to address 0x%04h", wb_adr));
            end
            @(negedge clk);
            #1;
        end
        // read data settles before the acknowledging edge
        rdata = wb_rdata;
        @(posedge clk);
        @(negedge clk);
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input opcode_e op, input logic [7:0] id, input wb_data_t data);
        wb_data_t ignored;
        bus_cycle(op, id, 1'b1, 4'hf, data, ignored);
    endtask

    task automatic wb_read(input opcode_e op, input logic [7:0] id, output wb_data_t data);
        bus_cycle(op, id, 1'b0, 4'hf, '0, data);
    endtask

    // lowest ready id, idle id when the set is empty
    function automatic tskid_t model_top();
        for (int i = 0; i < 15; i++) begin
            if (ready_model[i]) begin
                return tskid_t'(i);
            end
        end
        return tskid_t'(15);
    endfunction

    task automatic wake_task(input tskid_t id);
        wb_write(WUP_TSK, id, '0);
        ready_model[id] = 1'b1;
    endtask

    task automatic sleep_task(input tskid_t id);
        wb_write(SLP_TSK, id, '0);
        ready_model[id] = 1'b0;
    endtask

    task automatic check_top();
        wb_data_t rd;
        wb_read(CPU_CTL, TOP_TSKID, rd);
        check_data("TOP_TSKID", rd, wb_data_t'(model_top()));
        check_tskid("monitor_top_tskid_o", mon_top, model_top());
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq !== level) begin
            if (n == IRQ_WAIT_LIMIT) begin
                abort_run($sformatf("irq_o did not go to %b within %0d cycles",
                                    level, IRQ_WAIT_LIMIT));
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic signal_sem(input semid_t id);
        wb_write(SIG_SEM, id, '0);
        if (cnt_model[id] != 4'd15) begin
            cnt_model[id]++;
        end
    endtask

    task automatic poll_sem(input semid_t id);
        wb_data_t rd;
        logic     taken;
        wb_read(POL_SEM, id, rd);
        taken = (cnt_model[id] != 0);
        check_data($sformatf("POL_SEM[%0d]", id), rd, wb_data_t'(taken));
        if (taken) begin
            cnt_model[id]--;
        end
    endtask

    task automatic check_all_counts();
        for (int i = 0; i < 8; i++) begin
            check_semcnt($sformatf("monitor_semcnt_o[%0d]", i), mon_semcnt[i], cnt_model[i]);
        end
    endtask

    // --------------------------------------------------------------------
    // directed tests
    // --------------------------------------------------------------------

    task automatic test_config();
        wb_data_t rd;
        check_flag("wb_ack_o", wb_ack, 1'b0);
        check_flag("irq_o", irq, 1'b0);
        wb_read(SYS_CFG, CORE_ID, rd);
        check_data("CORE_ID", rd, 32'h834f5452);
        wb_read(SYS_CFG, TASKS, rd);
        check_data("TASKS", rd, 32'd15);
        wb_read(SYS_CFG, SEMAPHORES, rd);
        check_data("SEMAPHORES", rd, 32'd8);
        wb_read(SYS_CFG, FLGPTN_WIDTH, rd);
        check_data("FLGPTN_WIDTH", rd, 32'd32);
        wb_read(CPU_CTL, IDLE_TSKID, rd);
        check_data("IDLE_TSKID", rd, 32'd15);
        wb_read(CPU_CTL, TOP_VALID, rd);
        check_data("TOP_VALID", rd, 32'd0);
        wb_read(CPU_CTL, TOP_TSKID, rd);
        check_data("TOP_TSKID", rd, 32'd15);
    endtask

    task automatic test_ready_queue();
        wb_data_t rd;
        wake_task(9);
        check_top();
        wake_task(3);
        check_top();
        if (last_stalls != 1) begin
            abort_run("read right after a wake was not held for one cycle");
        end
        wake_task(12);
        check_top();
        sleep_task(3);
        check_top();
        // wake of task 1 with one byte lane off
        bus_cycle(WUP_TSK, 8'd1, 1'b1, 4'b0111, '0, rd);
        check_top();
        if (last_stalls != 0) begin
            abort_run("partial-sel write started a ready set update");
        end
        wb_read(CPU_CTL, TOP_VALID, rd);
        check_data("TOP_VALID", rd, 32'd1);
    endtask

    task automatic test_irq();
        wb_data_t rd;
        tskid_t   run_model;
        wb_read(CPU_CTL, COPY_TSKID, rd);
        run_model = model_top();
        check_data("COPY_TSKID", rd, wb_data_t'(run_model));
        wb_read(CPU_CTL, RUN_TSKID, rd);
        check_data("RUN_TSKID", rd, wb_data_t'(run_model));
        check_tskid("monitor_run_tskid_o", mon_run, run_model);
        wb_write(CPU_CTL, IRQ_EN, 32'd1);
        check_flag("irq_o", irq, 1'b0);
        // higher priority task becomes ready
        wake_task(2);
        wait_irq(1'b1);
        wb_read(CPU_CTL, IRQ_STS, rd);
        check_data("IRQ_STS", rd, 32'd1);
        wb_read(CPU_CTL, COPY_TSKID, rd);
        check_data("COPY_TSKID", rd, 32'd2);
        wait_irq(1'b0);
        wb_write(CPU_CTL, IRQ_EN, 32'd0);
        wb_write(CPU_CTL, IRQ_FORCE, 32'd1);
        check_flag("irq_o", irq, 1'b1);
        wb_write(CPU_CTL, IRQ_FORCE, 32'd0);
        check_flag("irq_o", irq, 1'b0);
    endtask

    task automatic test_semaphore();
        wb_data_t rd;
        repeat (3) signal_sem(5);
        wb_read(REF_SEMCNT, 8'd5, rd);
        check_data("REF_SEMCNT[5]", rd, 32'd3);
        repeat (4) poll_sem(5);
        check_all_counts();
        repeat (20) signal_sem(5);
        check_semcnt("monitor_semcnt_o[5]", mon_semcnt[5], 4'd15);
        check_all_counts();
        // no semaphore 13, reads zero
        wb_read(REF_SEMCNT, 8'd13, rd);
        check_data("REF_SEMCNT[13]", rd, 32'd0);
    endtask

    task automatic test_eventflag();
        flgptn_t pat;
        int      bit_n;
        repeat (6) begin
            pat = $urandom();
            wb_write(SET_FLG, 8'd0, pat);
            flg_model = flg_model | pat;
            check_flgptn("monitor_flg_o", mon_flg, flg_model);
            pat = $urandom();
            wb_write(CLR_FLG, 8'd0, pat);
            flg_model = flg_model & pat;
            check_flgptn("monitor_flg_o", mon_flg, flg_model);
        end
        bit_n = $urandom_range(31, 0);
        pat   = flgptn_t'(1) << bit_n;
        wb_write(CLR_FLG, 8'd0, ~pat);
        flg_model = flg_model & ~pat;
        ext_flg   = pat;
        repeat (3) @(negedge clk);
        check_flgptn("monitor_flg_o", mon_flg, flg_model);
        // mask takes effect one edge after the write
        wb_write(ENA_FLG_EXT, 8'd0, pat);
        @(negedge clk);
        flg_model = flg_model | pat;
        check_flgptn("monitor_flg_o", mon_flg, flg_model);
        ext_flg = '0;
        wb_write(ENA_FLG_EXT, 8'd0, '0);
        @(negedge clk);
        check_flgptn("monitor_flg_o", mon_flg, flg_model);
    endtask

    task automatic test_scratch();
        wb_data_t rd;
        for (int i = 0; i < 4; i++) begin
            scratch_model[i] = $urandom();
            wb_write(CPU_CTL, 8'(SCRATCH0 + i), scratch_model[i]);
        end
        for (int i = 0; i < 4; i++) begin
            wb_read(CPU_CTL, 8'(SCRATCH0 + i), rd);
            check_data($sformatf("SCRATCH%0d", i), rd, scratch_model[i]);
        end
    endtask

    task automatic test_soft_reset();
        wb_data_t rd;
        wb_write(SYS_CFG, SOFT_RESET, 32'd1);
        @(negedge clk);
        ready_model = '0;
        flg_model   = '0;
        foreach (cnt_model[i]) cnt_model[i] = '0;
        foreach (scratch_model[i]) scratch_model[i] = '0;
        check_flgptn("monitor_flg_o", mon_flg, flg_model);
        check_all_counts();
        wb_read(CPU_CTL, TOP_VALID, rd);
        check_data("TOP_VALID", rd, 32'd0);
        wb_read(CPU_CTL, TOP_TSKID, rd);
        check_data("TOP_TSKID", rd, 32'd15);
        wb_read(CPU_CTL, RUN_VALID, rd);
        check_data("RUN_VALID", rd, 32'd0);
        wb_read(REF_SEMCNT, 8'd5, rd);
        check_data("REF_SEMCNT[5]", rd, 32'd0);
        for (int i = 0; i < 4; i++) begin
            wb_read(CPU_CTL, 8'(SCRATCH0 + i), rd);
            check_data($sformatf("SCRATCH%0d", i), rd, scratch_model[i]);
        end
    endtask

    initial begin
        wb_adr      = '0;
        wb_wdata    = '0;
        wb_we       = 1'b0;
        wb_sel      = '0;
        wb_stb      = 1'b0;
        ext_flg     = '0;
        ready_model = '0;
        flg_model   = '0;
        foreach (cnt_model[i]) cnt_model[i] = '0;
        foreach (scratch_model[i]) scratch_model[i] = '0;
        void'($urandom(92));
        @(posedge rst_n);
        @(negedge clk);
        test_config();
        test_ready_queue();
        test_irq();
        test_semaphore();
        test_eventflag();
        test_scratch();
        test_soft_reset();
        $display("** PASS **");
        $finish;
    end

endmodule
